// File: sources.f
source/radio_regs_pkg.sv
source/radio_types_pkg.sv
source/settings_bus_mux.sv
source/timekeeper.sv
source/rx_framer.sv
source/radio_core.sv
source/radio_block.sv
dv/radio_block_asserts.sv
dv/radio_block_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module radio_block_tb \
  -o radio_block_tb
./obj_dir/radio_block_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
  exit 0
else
  exit 1
fi

// File: dv/radio_block_tb.sv
// Table-driven testbench for radio_block with NUM_RADIOS = 2 and SPP = 4
// Stream tests run on radio 0 only; VITA time is modeled from radio 0 rx strobes
// Inputs change on the falling edge and outputs are sampled there or just after

`timescale 1ns/1ns

module radio_block_tb import radio_regs_pkg::*, radio_types_pkg::*;;

  localparam int NR  = 2;
  localparam int SPP = 4;

  typedef enum logic [2:0] {
    OP_WR, OP_WR_BOTH, OP_RB, OP_RXPKT, OP_PPS, OP_TXLOOP, OP_UNDER, OP_STALL
  } op_e;
  typedef enum logic [2:0] {EXP_ROW, EXP_TIME, EXP_LASTPPS, EXP_OVF, EXP_UNF} exp_e;
  typedef struct packed {
    op_e         op;
    logic [7:0]  radio;
    logic [7:0]  addr;
    logic [31:0] data;
    logic [63:0] exp;
    exp_e        src;
    logic [7:0]  addr2;
    logic [31:0] data2;
  } row_t;

  logic                     ce_clk;
  logic                     i_rst;
  logic                     i_pps;
  logic [NR-1:0]            i_set_stb;
  logic [NR*SET_ADDR_W-1:0] i_set_addr;
  logic [NR*SET_DATA_W-1:0] i_set_data;
  logic [NR-1:0]            i_rb_stb;
  logic [NR*SET_ADDR_W-1:0] i_rb_addr;
  logic [NR*WORD_W-1:0]     o_rb_data;
  logic [NR-1:0]            o_rb_ack;
  logic [NR*SAMP_W-1:0]     i_rx;
  logic [NR-1:0]            i_rx_stb;
  logic [NR-1:0]            i_tx_stb;
  logic [NR*SAMP_W-1:0]     o_tx;
  logic [NR*SAMP_W-1:0]     i_tx_tdata;
  logic [NR-1:0]            i_tx_tvalid;
  logic [NR-1:0]            o_tx_tready;
  logic [NR*WORD_W-1:0]     o_rx_tdata;
  logic [NR-1:0]            o_rx_tlast;
  logic [NR-1:0]            o_rx_tvalid;
  logic [NR-1:0]            i_rx_tready;

  row_t              rows[$];
  integer            seed;
  int                cycles;
  int                timeout_limit;
  // Reference model state
  logic [TIME_W-1:0] model_time;
  logic [TIME_W-1:0] model_lastpps;
  logic [TIME_W-1:0] staged;
  logic              armed;
  logic [31:0]       ovf_model;
  logic [31:0]       unf_model;

  radio_block #(
    .NUM_RADIOS(NR),
    .SPP       (SPP)
  ) radio_block_inst (.*);

  always #5 ce_clk = ~ce_clk;

  always @(posedge ce_clk) begin
    cycles <= cycles + 1;
    if (timeout_limit != 0 && cycles >= timeout_limit) begin
      stop_run("Timeout: the test table did not finish within the cycle limit");
    end
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_rb(input string name, input logic [WORD_W-1:0] exp,
                          input logic [WORD_W-1:0] act);
    if (act !== exp) stop_run($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_word(input string name, input logic [WORD_W-1:0] exp,
                            input logic [WORD_W-1:0] act);
    if (act !== exp) stop_run($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_sample(input string name, input logic [SAMP_W-1:0] exp,
                              input logic [SAMP_W-1:0] act);
    if (act !== exp) stop_run($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) stop_run($sformatf("[ERROR] %s expected %b actual %b", name, exp, act));
  endtask

  task automatic add_row(input op_e op, input int r, input logic [7:0] a,
                         input logic [31:0] d, input logic [63:0] e, input exp_e src,
                         input logic [7:0] a2, input logic [31:0] d2);
    row_t row;
    row = '{op, 8'(r), a, d, e, src, a2, d2};
    rows.push_back(row);
  endtask

  // Time register side effects as the timekeeper sees them through the mux
  task automatic model_write(input logic [7:0] a, input logic [31:0] d);
    if (a == SR_TIME_HI) staged[63:32] = d;
    if (a == SR_TIME_LO) staged[31:0] = d;
    if (a == SR_TIME_CTRL && d[TIME_CTRL_NOW_BIT]) model_time = staged;
    if (a == SR_TIME_CTRL && d[TIME_CTRL_PPS_BIT]) armed = 1'b1;
  endtask

  task automatic write_regs(input row_t row, input logic both);
    i_set_stb[row.radio]                 = 1'b1;
    i_set_addr[row.radio*SET_ADDR_W +: SET_ADDR_W] = row.addr;
    i_set_data[row.radio*SET_DATA_W +: SET_DATA_W] = row.data;
    model_write(row.addr, row.data);
    if (both) begin
      i_set_stb[1]                           = 1'b1;
      i_set_addr[SET_ADDR_W +: SET_ADDR_W]   = row.addr2;
      i_set_data[SET_DATA_W +: SET_DATA_W]   = row.data2;
      model_write(row.addr2, row.data2);
    end
    @(negedge ce_clk);
    i_set_stb = '0;
    // Mux issue plus time load
    repeat (3) @(negedge ce_clk);
  endtask

  task automatic read_rb(input string name, input int r, input logic [7:0] a,
                         input logic [63:0] exp);
    int n;
    n = 0;
    i_rb_stb[r]                          = 1'b1;
    i_rb_addr[r*SET_ADDR_W +: SET_ADDR_W] = a;
    @(negedge ce_clk);
    i_rb_stb = '0;
    while (!o_rb_ack[r]) begin
      @(negedge ce_clk);
      n++;
      if (n > 8) stop_run($sformatf("%s: readback was never acknowledged", name));
    end
    check_rb(name, exp, o_rb_data[r*WORD_W +: WORD_W]);
    @(negedge ce_clk);
  endtask

  // One front end strobe on radio 0; tx strobes check the o_tx sample
  task automatic strobe(input string name, input logic use_tx, input logic valid,
                        input logic [31:0] s);
    if (use_tx) begin
      i_tx_tdata[31:0] = s;
      i_tx_tvalid[0]   = valid;
      i_tx_stb[0]      = 1'b1;
    end else begin
      i_rx[31:0]  = s;
      i_rx_stb[0] = 1'b1;
      model_time  = model_time + 1;
    end
    // Tready answers within the strobe cycle
    #1;
    if (use_tx) check_flag({name, "_tx_tready"}, valid, o_tx_tready[0]);
    @(negedge ce_clk);
    i_tx_stb[0]    = 1'b0;
    i_tx_tvalid[0] = 1'b0;
    i_rx_stb[0]    = 1'b0;
    if (use_tx) check_sample({name, "_o_tx"}, valid ? s : 32'd0, o_tx[31:0]);
  endtask

  task automatic send_packet(input string name, input logic use_tx, input int gap,
                             output logic [63:0] ts, output logic [31:0] samps[SPP]);
    ts = model_time;
    for (int s = 0; s < SPP; s++) begin
      samps[s] = $random(seed);
      strobe(name, use_tx, 1'b1, samps[s]);
      if (s < SPP - 1) repeat (gap) @(negedge ce_clk);
    end
  endtask

  task automatic collect_packet(input string name, input logic [63:0] ts,
                                input logic [31:0] samps[SPP]);
    int n;
    for (int w = 0; w <= SPP / 2; w++) begin
      n = 0;
      while (!o_rx_tvalid[0]) begin
        @(negedge ce_clk);
        n++;
        if (n > 50) stop_run($sformatf("%s: rx packet word %0d never arrived", name, w));
      end
      if (w == 0) check_word({name, "_header"}, ts, o_rx_tdata[63:0]);
      else check_word({name, "_payload"}, {samps[2*w-1], samps[2*w-2]}, o_rx_tdata[63:0]);
      check_flag({name, "_tlast"}, w == SPP / 2, o_rx_tlast[0]);
      @(negedge ce_clk);
    end
    // No extra word after tlast
    check_flag({name, "_tvalid_end"}, 1'b0, o_rx_tvalid[0]);
  endtask

  task automatic run_row(input int i, input row_t row);
    string       name;
    op_e         op;
    logic [63:0] ts;
    logic [63:0] exp;
    logic [31:0] samps[SPP];
    op   = row.op;
    name = $sformatf("row%0d_%s", i, op.name());
    case (op)
      OP_WR:      write_regs(row, 1'b0);
      OP_WR_BOTH: write_regs(row, 1'b1);
      OP_RB: begin
        case (row.src)
          EXP_TIME:    exp = model_time;
          EXP_LASTPPS: exp = model_lastpps;
          EXP_OVF:     exp = 64'(ovf_model);
          EXP_UNF:     exp = 64'(unf_model);
          default:     exp = row.exp;
        endcase
        read_rb(name, int'(row.radio), row.addr, exp);
      end
      OP_RXPKT: begin
        send_packet(name, 1'b0, 3, ts, samps);
        collect_packet(name, ts, samps);
      end
      OP_TXLOOP: begin
        send_packet(name, 1'b1, 1, ts, samps);
        collect_packet(name, ts, samps);
      end
      OP_UNDER: begin
        for (int k = 0; k < 3; k++) begin
          strobe(name, 1'b1, 1'b0, 32'hDEAD_BEEF);
          unf_model = unf_model + 1;
        end
      end
      OP_STALL: begin
        i_rx_tready[0] = 1'b0;
        send_packet(name, 1'b0, 1, ts, samps);
        for (int k = 0; k < 3; k++) begin
          strobe(name, 1'b0, 1'b1, $random(seed));
          ovf_model = ovf_model + 1;
          @(negedge ce_clk);
        end
        i_rx_tready[0] = 1'b1;
        collect_packet(name, ts, samps);
      end
      default: begin
        // PPS edge seen in the cycle after the pulse rises
        i_pps         = 1'b1;
        model_lastpps = model_time;
        if (armed) model_time = staged;
        armed = 1'b0;
        repeat (2) @(negedge ce_clk);
        i_pps = 1'b0;
        @(negedge ce_clk);
      end
    endcase
  endtask

  initial begin
    ce_clk        = 1'b0;
    i_rst         = 1'b1;
    i_pps         = 1'b0;
    i_set_stb     = '0;
    i_set_addr    = '0;
    i_set_data    = '0;
    i_rb_stb      = '0;
    i_rb_addr     = '0;
    i_rx          = '0;
    i_rx_stb      = '0;
    i_tx_stb      = '0;
    i_tx_tdata    = '0;
    i_tx_tvalid   = '0;
    i_rx_tready   = '1;
    seed          = 32'h271e4d1d;
    cycles        = 0;
    timeout_limit = 0;
    model_time    = '0;
    model_lastpps = '0;
    staged        = '0;
    armed         = 1'b0;
    ovf_model     = '0;
    unf_model     = '0;

    ////////////////////
    // Test table
    ////////////////////
    add_row(OP_WR, 0, SR_TEST, 32'hA5A5_0001, 0, EXP_ROW, 0, 0);
    add_row(OP_WR, 1, SR_TEST, 32'h5A5A_0002, 0, EXP_ROW, 0, 0);
    add_row(OP_RB, 0, RB_TEST, 0, 64'hA5A5_0001, EXP_ROW, 0, 0);
    add_row(OP_RB, 1, RB_TEST, 0, 64'h5A5A_0002, EXP_ROW, 0, 0);
    add_row(OP_RB, 0, RB_RADIO_NUM, 0, 64'd0, EXP_ROW, 0, 0);
    add_row(OP_RB, 1, RB_RADIO_NUM, 0, 64'd1, EXP_ROW, 0, 0);
    // Both radios hit the time halves in one cycle
    add_row(OP_WR_BOTH, 0, SR_TIME_HI, 32'h12, 0, EXP_ROW, SR_TIME_LO, 32'h3400_0000);
    add_row(OP_WR, 0, SR_TIME_CTRL, 32'h1, 0, EXP_ROW, 0, 0);
    add_row(OP_RB, 1, RB_VITA_TIME, 0, 0, EXP_TIME, 0, 0);
    add_row(OP_WR, 0, SR_RX_CTRL, 32'h1, 0, EXP_ROW, 0, 0);
    add_row(OP_RXPKT, 0, 0, 0, 0, EXP_ROW, 0, 0);
    add_row(OP_RB, 0, RB_VITA_TIME, 0, 0, EXP_TIME, 0, 0);
    // Load at the next PPS
    add_row(OP_WR, 0, SR_TIME_HI, 32'h100, 0, EXP_ROW, 0, 0);
    add_row(OP_WR, 1, SR_TIME_LO, 32'h40, 0, EXP_ROW, 0, 0);
    add_row(OP_WR, 1, SR_TIME_CTRL, 32'h2, 0, EXP_ROW, 0, 0);
    add_row(OP_RB, 0, RB_VITA_TIME, 0, 0, EXP_TIME, 0, 0);
    add_row(OP_PPS, 0, 0, 0, 0, EXP_ROW, 0, 0);
    add_row(OP_RB, 0, RB_VITA_LASTPPS, 0, 0, EXP_LASTPPS, 0, 0);
    add_row(OP_RXPKT, 0, 0, 0, 0, EXP_ROW, 0, 0);
    add_row(OP_RB, 0, RB_VITA_TIME, 0, 0, EXP_TIME, 0, 0);
    // Loopback and underflow
    add_row(OP_WR, 0, SR_RX_CTRL, 32'h3, 0, EXP_ROW, 0, 0);
    add_row(OP_WR, 0, SR_TX_CTRL, 32'h1, 0, EXP_ROW, 0, 0);
    add_row(OP_TXLOOP, 0, 0, 0, 0, EXP_ROW, 0, 0);
    add_row(OP_WR, 0, SR_RX_CTRL, 32'h0, 0, EXP_ROW, 0, 0);
    add_row(OP_UNDER, 0, 0, 0, 0, EXP_ROW, 0, 0);
    add_row(OP_RB, 0, RB_TX_UNDERFLOW, 0, 0, EXP_UNF, 0, 0);
    // Back-pressure
    add_row(OP_WR, 0, SR_RX_CTRL, 32'h1, 0, EXP_ROW, 0, 0);
    add_row(OP_STALL, 0, 0, 0, 0, EXP_ROW, 0, 0);
    add_row(OP_RB, 0, RB_RX_OVERFLOW, 0, 0, EXP_OVF, 0, 0);
    add_row(OP_RB, 0, RB_VITA_TIME, 0, 0, EXP_TIME, 0, 0);
    timeout_limit = rows.size() * 64;

    repeat (5) @(posedge ce_clk);
    @(negedge ce_clk);
    i_rst = 0;
    @(negedge ce_clk);
    for (int i = 0; i < rows.size(); i++) run_row(i, rows[i]);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// File: dv/radio_block_asserts.sv
// Protocol checks on the radio_block strobes and streams for each radio

`timescale 1ns/1ns

module radio_block_asserts import radio_types_pkg::*; #(
  parameter int NUM_RADIOS = 2
) (
  input logic                         ce_clk,
  input logic                         i_rst,
  input logic [NUM_RADIOS-1:0]        i_rb_stb,
  input logic [NUM_RADIOS-1:0]        o_rb_ack,
  input logic [NUM_RADIOS-1:0]        i_tx_stb,
  input logic [NUM_RADIOS*SAMP_W-1:0] i_tx_tdata,
  input logic [NUM_RADIOS-1:0]        o_tx_tready,
  input logic [NUM_RADIOS*SAMP_W-1:0] o_tx,
  input logic [NUM_RADIOS*WORD_W-1:0] o_rx_tdata,
  input logic [NUM_RADIOS-1:0]        o_rx_tvalid,
  input logic [NUM_RADIOS-1:0]        i_rx_tready
);

  for (genvar i = 0; i < NUM_RADIOS; i++) begin : gen_chk
    // Ack exactly one cycle after the readback strobe
    assert property (@(posedge ce_clk) disable iff (i_rst) o_rb_ack[i] == $past(i_rb_stb[i]))
      else $error("rb ack timing wrong on radio %0d", i);
    assert property (@(posedge ce_clk) disable iff (i_rst)
      (o_rx_tvalid[i] && !i_rx_tready[i]) |=>
        (o_rx_tvalid[i] && $stable(o_rx_tdata[i*WORD_W +: WORD_W])))
      else $error("rx stream changed while stalled on radio %0d", i);
    // A taken tx sample came with a strobe and plays out on the next cycle
    assert property (@(posedge ce_clk) disable iff (i_rst)
      o_tx_tready[i] |=> ($past(i_tx_stb[i]) &&
        (o_tx[i*SAMP_W +: SAMP_W] == $past(i_tx_tdata[i*SAMP_W +: SAMP_W]))))
      else $error("tx tready without strobe or sample not played on radio %0d", i);
  end

endmodule

bind radio_block radio_block_asserts #(.NUM_RADIOS(NUM_RADIOS)) radio_block_asserts_inst (
  .ce_clk     (ce_clk),
  .i_rst      (i_rst),
  .i_rb_stb   (i_rb_stb),
  .o_rb_ack   (o_rb_ack),
  .i_tx_stb   (i_tx_stb),
  .i_tx_tdata (i_tx_tdata),
  .o_tx_tready(o_tx_tready),
  .o_tx       (o_tx),
  .o_rx_tdata (o_rx_tdata),
  .o_rx_tvalid(o_rx_tvalid),
  .i_rx_tready(i_rx_tready)
);

// File: source/radio_block.sv
// Top level: NUM_RADIOS radio cores sharing one timekeeper
// VITA time counts radio 0's rx strobes only
// Per-radio buses are packed, radio 0 in the low slice

`timescale 1ns/1ns

module radio_block import radio_types_pkg::*; #(
  parameter int NUM_RADIOS = 2,
  parameter int SPP        = 4
) (
  input  logic                             ce_clk,
  input  logic                             i_rst,
  input  logic                             i_pps,
  input  logic [NUM_RADIOS-1:0]            i_set_stb,
  input  logic [NUM_RADIOS*SET_ADDR_W-1:0] i_set_addr,
  input  logic [NUM_RADIOS*SET_DATA_W-1:0] i_set_data,
  input  logic [NUM_RADIOS-1:0]            i_rb_stb,
  input  logic [NUM_RADIOS*SET_ADDR_W-1:0] i_rb_addr,
  output logic [NUM_RADIOS*WORD_W-1:0]     o_rb_data,
  output logic [NUM_RADIOS-1:0]            o_rb_ack,
  input  logic [NUM_RADIOS*SAMP_W-1:0]     i_rx,
  input  logic [NUM_RADIOS-1:0]            i_rx_stb,
  input  logic [NUM_RADIOS-1:0]            i_tx_stb,
  output logic [NUM_RADIOS*SAMP_W-1:0]     o_tx,
  input  logic [NUM_RADIOS*SAMP_W-1:0]     i_tx_tdata,
  input  logic [NUM_RADIOS-1:0]            i_tx_tvalid,
  output logic [NUM_RADIOS-1:0]            o_tx_tready,
  output logic [NUM_RADIOS*WORD_W-1:0]     o_rx_tdata,
  output logic [NUM_RADIOS-1:0]            o_rx_tlast,
  output logic [NUM_RADIOS-1:0]            o_rx_tvalid,
  input  logic [NUM_RADIOS-1:0]            i_rx_tready
);

  logic                  set_stb_mux;
  logic [SET_ADDR_W-1:0] set_addr_mux;
  logic [SET_DATA_W-1:0] set_data_mux;
  logic [TIME_W-1:0]     vita_time;
  logic [TIME_W-1:0]     vita_time_lastpps;

  ////////////////////
  // Shared time
  ////////////////////
  settings_bus_mux #(
    .NUM_RADIOS(NUM_RADIOS)
  ) settings_bus_mux_inst (
    .ce_clk    (ce_clk),
    .i_rst     (i_rst),
    .i_set_stb (i_set_stb),
    .i_set_addr(i_set_addr),
    .i_set_data(i_set_data),
    .o_set_stb (set_stb_mux),
    .o_set_addr(set_addr_mux),
    .o_set_data(set_data_mux)
  );

  timekeeper timekeeper_inst (
    .ce_clk             (ce_clk),
    .i_rst              (i_rst),
    .i_pps              (i_pps),
    .i_strobe           (i_rx_stb[0]),
    .i_set_stb          (set_stb_mux),
    .i_set_addr         (set_addr_mux),
    .i_set_data         (set_data_mux),
    .o_vita_time        (vita_time),
    .o_vita_time_lastpps(vita_time_lastpps)
  );

  ////////////////////
  // Radio cores
  ////////////////////
  for (genvar i = 0; i < NUM_RADIOS; i++) begin : gen_radio
    radio_core #(
      .RADIO_NUM(i),
      .SPP      (SPP)
    ) radio_core_inst (
      .ce_clk             (ce_clk),
      .i_rst              (i_rst),
      .i_set_stb          (i_set_stb[i]),
      .i_set_addr         (i_set_addr[i*SET_ADDR_W +: SET_ADDR_W]),
      .i_set_data         (i_set_data[i*SET_DATA_W +: SET_DATA_W]),
      .i_rb_stb           (i_rb_stb[i]),
      .i_rb_addr          (i_rb_addr[i*SET_ADDR_W +: SET_ADDR_W]),
      .o_rb_data          (o_rb_data[i*WORD_W +: WORD_W]),
      .o_rb_ack           (o_rb_ack[i]),
      .i_vita_time        (vita_time),
      .i_vita_time_lastpps(vita_time_lastpps),
      .i_rx               (i_rx[i*SAMP_W +: SAMP_W]),
      .i_rx_stb           (i_rx_stb[i]),
      .i_tx_stb           (i_tx_stb[i]),
      .o_tx               (o_tx[i*SAMP_W +: SAMP_W]),
      .i_tx_tdata         (i_tx_tdata[i*SAMP_W +: SAMP_W]),
      .i_tx_tvalid        (i_tx_tvalid[i]),
      .o_tx_tready        (o_tx_tready[i]),
      .o_rx_tdata         (o_rx_tdata[i*WORD_W +: WORD_W]),
      .o_rx_tlast         (o_rx_tlast[i]),
      .o_rx_tvalid        (o_rx_tvalid[i]),
      .i_rx_tready        (i_rx_tready[i])
    );
  end

endmodule

// File: source/radio_core.sv
// One radio: control registers, readback, tx playout and rx framing
// Readback answers exactly one cycle after i_rb_stb; unknown addresses give zero
// With loopback set, the framer takes the tx samples instead of i_rx

`timescale 1ns/1ns

module radio_core import radio_regs_pkg::*, radio_types_pkg::*; #(
  parameter int RADIO_NUM = 0,
  parameter int SPP       = 4
) (
  input  logic                  ce_clk,
  input  logic                  i_rst,
  input  logic                  i_set_stb,
  input  logic [SET_ADDR_W-1:0] i_set_addr,
  input  logic [SET_DATA_W-1:0] i_set_data,
  input  logic                  i_rb_stb,
  input  logic [SET_ADDR_W-1:0] i_rb_addr,
  output logic [WORD_W-1:0]     o_rb_data,
  output logic                  o_rb_ack,
  input  logic [TIME_W-1:0]     i_vita_time,
  input  logic [TIME_W-1:0]     i_vita_time_lastpps,
  input  logic [SAMP_W-1:0]     i_rx,
  input  logic                  i_rx_stb,
  input  logic                  i_tx_stb,
  output logic [SAMP_W-1:0]     o_tx,
  input  logic [SAMP_W-1:0]     i_tx_tdata,
  input  logic                  i_tx_tvalid,
  output logic                  o_tx_tready,
  output logic [WORD_W-1:0]     o_rx_tdata,
  output logic                  o_rx_tlast,
  output logic                  o_rx_tvalid,
  input  logic                  i_rx_tready
);

  logic [SET_DATA_W-1:0] test_reg;
  logic                  rx_en;
  logic                  loopback;
  logic                  tx_en;
  logic [31:0]           underflow_count;
  logic [31:0]           overflow_count;
  logic [SAMP_W-1:0]     tx_next;
  logic [SAMP_W-1:0]     fr_sample;
  logic                  fr_stb;

  ////////////////////
  // Settings decode
  ////////////////////
  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      test_reg <= '0;
      rx_en    <= 1'b0;
      loopback <= 1'b0;
      tx_en    <= 1'b0;
    end else if (i_set_stb) begin
      case (i_set_addr)
        SR_TEST:    test_reg <= i_set_data;
        SR_RX_CTRL: begin
          rx_en    <= i_set_data[RX_CTRL_EN_BIT];
          loopback <= i_set_data[RX_CTRL_LOOP_BIT];
        end
        SR_TX_CTRL: tx_en <= i_set_data[TX_CTRL_EN_BIT];
        default: ;
      endcase
    end
  end

  ////////////////////
  // Tx playout
  ////////////////////
  // Take a sample only on a front end strobe
  assign o_tx_tready = i_tx_stb && tx_en && i_tx_tvalid;
  assign tx_next     = o_tx_tready ? i_tx_tdata : '0;

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      o_tx            <= '0;
      underflow_count <= '0;
    end else if (i_tx_stb) begin
      o_tx <= tx_next;
      if (tx_en && !i_tx_tvalid) underflow_count <= underflow_count + 32'd1;
    end
  end

  // Loopback sees the same sample that goes out on o_tx
  assign fr_sample = loopback ? tx_next : i_rx;
  assign fr_stb    = loopback ? i_tx_stb : i_rx_stb;

  rx_framer #(
    .SPP(SPP)
  ) rx_framer_inst (
    .ce_clk          (ce_clk),
    .i_rst           (i_rst),
    .i_enable        (rx_en),
    .i_sample        (fr_sample),
    .i_sample_stb    (fr_stb),
    .i_vita_time     (i_vita_time),
    .o_tdata         (o_rx_tdata),
    .o_tlast         (o_rx_tlast),
    .o_tvalid        (o_rx_tvalid),
    .i_tready        (i_rx_tready),
    .o_overflow_count(overflow_count)
  );

  ////////////////////
  // Readback
  ////////////////////
  always_ff @(posedge ce_clk) begin
    if (i_rst) o_rb_ack <= 1'b0;
    else o_rb_ack <= i_rb_stb;
  end

  always_ff @(posedge ce_clk) begin
    if (i_rb_stb) begin
      case (i_rb_addr)
        RB_TEST:         o_rb_data <= WORD_W'(test_reg);
        RB_VITA_TIME:    o_rb_data <= i_vita_time;
        RB_VITA_LASTPPS: o_rb_data <= i_vita_time_lastpps;
        RB_RX_OVERFLOW:  o_rb_data <= WORD_W'(overflow_count);
        RB_TX_UNDERFLOW: o_rb_data <= WORD_W'(underflow_count);
        RB_RADIO_NUM:    o_rb_data <= WORD_W'(RADIO_NUM);
        default:         o_rb_data <= '0;
      endcase
    end
  end

endmodule

// File: source/rx_framer.sv
// Packs SPP samples into one header word plus SPP/2 payload words
// SPP must be even; disabling rx drops a partly filled packet
// Samples arriving while a packet is out are lost and counted

`timescale 1ns/1ns

module rx_framer import radio_types_pkg::*; #(
  parameter int SPP = 4
) (
  input  logic              ce_clk,
  input  logic              i_rst,
  input  logic              i_enable,
  input  logic [SAMP_W-1:0] i_sample,
  input  logic              i_sample_stb,
  input  logic [TIME_W-1:0] i_vita_time,
  output logic [WORD_W-1:0] o_tdata,
  output logic              o_tlast,
  output logic              o_tvalid,
  input  logic              i_tready,
  output logic [31:0]       o_overflow_count
);

  localparam int IDX_W = $clog2(SPP);
  localparam int WORDS = SPP / 2;

  framer_state_e     state;
  logic [IDX_W-1:0]  idx;
  logic [SAMP_W-1:0] samp_buf [SPP];
  logic [TIME_W-1:0] ts;
  logic              capture;

  assign capture = i_enable && i_sample_stb && (state == FR_CAPTURE);

  // Outputs come straight from registers, so they hold under back-pressure
  assign o_tvalid = (state != FR_CAPTURE);
  assign o_tlast  = (state == FR_PAYLOAD) && (idx == IDX_W'(WORDS - 1));

  always_comb begin
    case (state)
      FR_PAYLOAD: o_tdata = {samp_buf[2*idx+1], samp_buf[2*idx]};
      default:    o_tdata = ts;
    endcase
  end

  // Sample store, timestamp taken with the first sample
  always_ff @(posedge ce_clk) begin
    if (capture) begin
      samp_buf[idx] <= i_sample;
      if (idx == '0) ts <= i_vita_time;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      state            <= FR_CAPTURE;
      idx              <= '0;
      o_overflow_count <= '0;
    end else begin
      if (i_enable && i_sample_stb && (state != FR_CAPTURE)) begin
        o_overflow_count <= o_overflow_count + 32'd1;
      end
      case (state)
        FR_CAPTURE: begin
          if (!i_enable) begin
            idx <= '0;
          end else if (i_sample_stb) begin
            if (idx == IDX_W'(SPP - 1)) begin
              idx   <= '0;
              state <= FR_HEADER;
            end else begin
              idx <= idx + 1'b1;
            end
          end
        end
        FR_HEADER: begin
          if (i_tready) state <= FR_PAYLOAD;
        end
        FR_PAYLOAD: begin
          if (i_tready) begin
            if (o_tlast) begin
              idx   <= '0;
              state <= FR_CAPTURE;
            end else begin
              idx <= idx + 1'b1;
            end
          end
        end
        default: state <= FR_CAPTURE;
      endcase
    end
  end

endmodule

// File: source/timekeeper.sv
// VITA time counter, one tick per sample strobe
// i_pps must already be synchronous to ce_clk
// A time load beats a strobe in the same cycle

`timescale 1ns/1ns

module timekeeper import radio_regs_pkg::*, radio_types_pkg::*; (
  input  logic                  ce_clk,
  input  logic                  i_rst,
  input  logic                  i_pps,
  input  logic                  i_strobe,
  input  logic                  i_set_stb,
  input  logic [SET_ADDR_W-1:0] i_set_addr,
  input  logic [SET_DATA_W-1:0] i_set_data,
  output logic [TIME_W-1:0]     o_vita_time,
  output logic [TIME_W-1:0]     o_vita_time_lastpps
);

  logic [SET_DATA_W-1:0] time_hi;
  logic [SET_DATA_W-1:0] time_lo;
  logic                  set_ctrl;
  logic                  set_now;
  logic                  armed;
  logic                  pps_d;
  logic                  pps_edge;
  logic                  load;

  assign set_ctrl = i_set_stb && (i_set_addr == SR_TIME_CTRL);
  assign set_now  = set_ctrl && i_set_data[TIME_CTRL_NOW_BIT];
  assign pps_edge = i_pps && !pps_d;
  assign load     = set_now || (armed && pps_edge);

  ////////////////////
  // Staged time halves
  ////////////////////
  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      time_hi <= '0;
      time_lo <= '0;
    end else if (i_set_stb) begin
      if (i_set_addr == SR_TIME_HI) time_hi <= i_set_data;
      if (i_set_addr == SR_TIME_LO) time_lo <= i_set_data;
    end
  end

  ////////////////////
  // PPS edge, arming and counter
  ////////////////////
  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      pps_d               <= 1'b0;
      armed               <= 1'b0;
      o_vita_time         <= '0;
      o_vita_time_lastpps <= '0;
    end else begin
      pps_d <= i_pps;
      // Arm waits for the next edge, even one in this cycle's load
      if (set_ctrl && i_set_data[TIME_CTRL_PPS_BIT]) armed <= 1'b1;
      else if (pps_edge) armed <= 1'b0;

      if (load) o_vita_time <= {time_hi, time_lo};
      else if (i_strobe) o_vita_time <= o_vita_time + 1'b1;

      // Time seen at the edge, before any load
      if (pps_edge) o_vita_time_lastpps <= o_vita_time;
    end
  end

endmodule

// File: source/settings_bus_mux.sv
// Merges NUM_RADIOS settings buses into one, lowest index first
// A bus may write at most once per NUM_RADIOS cycles or writes can be lost
// Output is registered, so an uncontested write appears one cycle later

`timescale 1ns/1ns

module settings_bus_mux import radio_types_pkg::*; #(
  parameter int NUM_RADIOS = 2
) (
  input  logic                             ce_clk,
  input  logic                             i_rst,
  input  logic [NUM_RADIOS-1:0]            i_set_stb,
  input  logic [NUM_RADIOS*SET_ADDR_W-1:0] i_set_addr,
  input  logic [NUM_RADIOS*SET_DATA_W-1:0] i_set_data,
  output logic                             o_set_stb,
  output logic [SET_ADDR_W-1:0]            o_set_addr,
  output logic [SET_DATA_W-1:0]            o_set_data
);

  localparam int IDX_W = (NUM_RADIOS > 1) ? $clog2(NUM_RADIOS) : 1;

  logic [NUM_RADIOS-1:0] pend_vld;
  logic [SET_ADDR_W-1:0] pend_addr [NUM_RADIOS];
  logic [SET_DATA_W-1:0] pend_data [NUM_RADIOS];

  logic [NUM_RADIOS-1:0] cand_vld;
  logic [SET_ADDR_W-1:0] cand_addr [NUM_RADIOS];
  logic [SET_DATA_W-1:0] cand_data [NUM_RADIOS];
  logic                  issue_vld;
  logic [IDX_W-1:0]      issue_idx;

  // A held write takes precedence over a new one on the same bus
  always_comb begin
    for (int i = 0; i < NUM_RADIOS; i++) begin
      cand_vld[i]  = pend_vld[i] | i_set_stb[i];
      cand_addr[i] = pend_vld[i] ? pend_addr[i] : i_set_addr[i*SET_ADDR_W +: SET_ADDR_W];
      cand_data[i] = pend_vld[i] ? pend_data[i] : i_set_data[i*SET_DATA_W +: SET_DATA_W];
    end
  end

  // Fixed priority, scanned downward so the lowest index wins
  always_comb begin
    issue_vld = 1'b0;
    issue_idx = '0;
    for (int i = NUM_RADIOS - 1; i >= 0; i--) begin
      if (cand_vld[i]) begin
        issue_vld = 1'b1;
        issue_idx = IDX_W'(i);
      end
    end
  end

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      pend_vld  <= '0;
      o_set_stb <= 1'b0;
    end else begin
      for (int i = 0; i < NUM_RADIOS; i++) begin
        pend_vld[i] <= cand_vld[i] && (issue_idx != IDX_W'(i));
      end
      o_set_stb <= issue_vld;
    end
  end

  always_ff @(posedge ce_clk) begin
    for (int i = 0; i < NUM_RADIOS; i++) begin
      pend_addr[i] <= cand_addr[i];
      pend_data[i] <= cand_data[i];
    end
    o_set_addr <= cand_addr[issue_idx];
    o_set_data <= cand_data[issue_idx];
  end

endmodule

// File: source/radio_types_pkg.sv
// Bus, sample and time widths shared across the radio block
// TIME_W must equal two settings data words for the time halves to line up

package radio_types_pkg;

  // Settings bus
  localparam int SET_ADDR_W = 8;
  localparam int SET_DATA_W = 32;

  // Front end sample, one complex 16+16 pair
  localparam int SAMP_W = 32;

  // Stream word and VITA time
  localparam int WORD_W = 64;
  localparam int TIME_W = 64;

  // Rx framer states
  typedef enum logic [1:0] {
    FR_CAPTURE,
    FR_HEADER,
    FR_PAYLOAD
  } framer_state_e;

endpackage

// File: source/radio_regs_pkg.sv
// Settings and readback address map for the radio cores and the timekeeper
// Settings addresses sit above 0x80; readback addresses are a separate space

package radio_regs_pkg;

  // Settings bus addresses
  typedef enum logic [7:0] {
    SR_TEST      = 8'h80,
    SR_RX_CTRL   = 8'h81,
    SR_TX_CTRL   = 8'h82,
    SR_TIME_HI   = 8'h88,
    SR_TIME_LO   = 8'h89,
    SR_TIME_CTRL = 8'h8A
  } sr_addr_e;

  // Readback addresses, answered one cycle after the strobe
  typedef enum logic [7:0] {
    RB_TEST         = 8'd0,
    RB_VITA_TIME    = 8'd1,
    RB_VITA_LASTPPS = 8'd2,
    RB_RX_OVERFLOW  = 8'd3,
    RB_TX_UNDERFLOW = 8'd4,
    RB_RADIO_NUM    = 8'd5
  } rb_addr_e;

  // Control register bit positions
  localparam int RX_CTRL_EN_BIT    = 0;
  localparam int RX_CTRL_LOOP_BIT  = 1;
  localparam int TX_CTRL_EN_BIT    = 0;
  localparam int TIME_CTRL_NOW_BIT = 0;
  localparam int TIME_CTRL_PPS_BIT = 1;

endpackage
